// File: hbm_emu.f
hw/hbm_emu_pkg.sv
hw/float_pattern_gen.sv
hw/hbm_channel_emu.sv
hw/emu_config_regs.sv
hw/hbm_emu_top.sv
sim/hbm_emu_checker.sv
sim/tb_hbm_emu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

if ! cd "$(dirname "$0")"; then
    echo "cannot enter project root"
    exit 1
fi

if ! verilator --binary --timing --top-module tb_hbm_emu -f hbm_emu.f -o tb_hbm_emu; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_hbm_emu)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" <<< "$output"; then
    exit 0
else
    echo "simulation did not report a clean run"
    exit 1
fi

// File: sim/tb_hbm_emu.sv
`timescale 1ns/1ps

module tb_hbm_emu import hbm_emu_pkg::*; ();

    localparam int wait_limit  = 200;  // cycles per handshake
    localparam int sel_arready = 0;
    localparam int sel_awready = 1;
    localparam int sel_wready  = 2;
    localparam int sel_bvalid  = 3;

    logic       ap_clk;
    logic       rst;
    axi_ar_t    ar;
    logic       arvalid;
    logic       arready;
    axi_aw_t    aw;
    logic       awvalid;
    logic       awready;
    axi_w_t     w;
    logic       wvalid;
    logic       wready;
    axi_r_t     r;
    logic       rvalid;
    logic       rready;
    logic       bvalid;
    logic       bready;
    logic       cfg_we;
    logic [1:0] cfg_addr;
    count_t     cfg_wdata;
    count_t     cfg_rdata;
    logic       reg_check;

    int          err_count;
    int          check_count;
    int          err_before;
    int          test_num;
    int          tests_failed;
    logic [31:0] rng;
    logic        timed_out;
    string       timeout_what;

    hbm_emu_top u_dut (
        .ap_clk (ap_clk), .rst (rst),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .r (r), .rvalid (rvalid), .rready (rready),
        .bvalid (bvalid), .bready (bready),
        .cfg_we (cfg_we), .cfg_addr (cfg_addr),
        .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata)
    );

    hbm_emu_checker u_chk (
        .ap_clk (ap_clk), .rst (rst),
        .ar (ar), .arvalid (arvalid), .arready (arready),
        .aw (aw), .awvalid (awvalid), .awready (awready),
        .w (w), .wvalid (wvalid), .wready (wready),
        .r (r), .rvalid (rvalid), .rready (rready),
        .bvalid (bvalid), .bready (bready),
        .cfg_we (cfg_we), .cfg_addr (cfg_addr),
        .cfg_wdata (cfg_wdata), .cfg_rdata (cfg_rdata),
        .reg_check (reg_check),
        .err_count (err_count), .check_count (check_count)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic flag_of(input int sel);
        case (sel)
            sel_arready: return arready;
            sel_awready: return awready;
            sel_wready:  return wready;
            default:     return bvalid;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    // hands off to the watchdog and parks this process
    task automatic abort_on_timeout(input string what);
        timeout_what = what;
        timed_out = 1'b1;
        forever @(posedge ap_clk);
    endtask

    initial begin
        wait (timed_out === 1'b1);
        $display("timeout: %s did not arrive within %0d cycles", timeout_what, wait_limit);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic wait_flag(input int sel, input string what);
        int cycles;
        cycles = 0;
        @(negedge ap_clk);
        while (!flag_of(sel)) begin
            cycles++;
            if (cycles > wait_limit) begin
                abort_on_timeout(what);
            end
            @(negedge ap_clk);
        end
    endtask

    task automatic read_burst(input int len, input logic stall);
        int got;
        int idle_cycles;
        rng = xorshift32(rng);
        ar.addr = {rng, rng};
        ar.len = burst_len_t'(len);
        arvalid = 1'b1;
        wait_flag(sel_arready, "arready");
        next_cycle();
        arvalid = 1'b0;
        got = 0;
        idle_cycles = 0;
        while (got <= len) begin
            rng = xorshift32(rng);
            rready = stall ? rng[0] : 1'b1;
            @(negedge ap_clk);
            if (rvalid && rready) begin
                got++;
            end else begin
                idle_cycles++;
                if (idle_cycles > wait_limit) begin
                    abort_on_timeout("r beat");
                end
            end
            next_cycle();
        end
        rready = 1'b0;
    endtask

    task automatic write_burst(input int len);
        rng = xorshift32(rng);
        aw.addr = {rng, rng};
        aw.len = burst_len_t'(len);
        awvalid = 1'b1;
        wait_flag(sel_awready, "awready");
        next_cycle();
        awvalid = 1'b0;
        for (int i = 0; i <= len; i++) begin
            rng = xorshift32(rng);
            repeat (rng[1:0]) next_cycle(); // wvalid gap
            w.data = {floats_per_beat{rng}};
            w.last = (i == len);
            wvalid = 1'b1;
            wait_flag(sel_wready, "wready");
            next_cycle();
            wvalid = 1'b0;
        end
        w.last = 1'b0;
        rng = xorshift32(rng);
        repeat (rng[2:0]) next_cycle();     // bready held off
        bready = 1'b1;
        wait_flag(sel_bvalid, "bvalid");
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic write_reg(input logic [1:0] addr, input count_t data);
        cfg_addr = addr;
        cfg_wdata = data;
        cfg_we = 1'b1;
        next_cycle();
        cfg_we = 1'b0;
    endtask

    task automatic check_reg(input logic [1:0] addr);
        cfg_addr = addr;
        reg_check = 1'b1;
        next_cycle();
        reg_check = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs = err_count - err_before;
        test_num++;
        if (errs == 0) begin
            $display("test %0d %s: pass", test_num, name);
        end else begin
            $display("test %0d %s: %0d mismatches", test_num, name, errs);
            tests_failed++;
        end
        err_before = err_count;
    endtask

    initial begin
        rst = 1'b1;
        ar = '0;
        arvalid = 1'b0;
        aw = '0;
        awvalid = 1'b0;
        w = '0;
        w.strb = '1;
        wvalid = 1'b0;
        rready = 1'b0;
        bready = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        reg_check = 1'b0;
        rng = 32'h89e04deb;
        timed_out = 1'b0;
        err_before = 0;
        test_num = 0;
        tests_failed = 0;
        repeat (16) @(posedge ap_clk);
        #1;
        rst = 1'b0;

        repeat (2) next_cycle();
        for (int a = 0; a < 4; a++) begin
            check_reg(2'(a));
        end
        finish_test("reset state");

        repeat (6) begin
            rng = xorshift32(rng);
            read_burst(int'(rng[3:0]), 1'b0);
        end
        finish_test("read burst content");

        repeat (6) begin
            rng = xorshift32(rng);
            read_burst(int'(rng[3:0]), 1'b1);
        end
        finish_test("read back-pressure");

        repeat (6) begin
            rng = xorshift32(rng);
            write_burst(int'(rng[3:0]));
        end
        finish_test("write bursts");

        repeat (3) begin
            rng = xorshift32(rng);
            write_reg(reg_pattern_offset, {rng[31:5], 2'b11, rng[2:0]}); // 24..31, wraps
            check_reg(reg_pattern_offset);
            read_burst(15, rng[3]);
        end
        finish_test("offset register");

        repeat (12) begin
            rng = xorshift32(rng);
            if (rng[0]) begin
                read_burst(int'(rng[7:4]), rng[1]);
            end else begin
                write_burst(int'(rng[7:4]));
            end
        end
        repeat (4) next_cycle();            // counters trail the transfers
        check_reg(reg_rd_bursts);
        check_reg(reg_rd_beats);
        check_reg(reg_wr_beats);
        finish_test("status counters");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
                 test_num, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: sim/hbm_emu_checker.sv
`timescale 1ns/1ps

module hbm_emu_checker import hbm_emu_pkg::*; (
    input  logic       ap_clk,
    input  logic       rst,

    input  axi_ar_t    ar,
    input  logic       arvalid,
    input  logic       arready,
    input  axi_aw_t    aw,
    input  logic       awvalid,
    input  logic       awready,
    input  axi_w_t     w,
    input  logic       wvalid,
    input  logic       wready,
    input  axi_r_t     r,
    input  logic       rvalid,
    input  logic       rready,
    input  logic       bvalid,
    input  logic       bready,

    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  count_t     cfg_wdata,
    input  count_t     cfg_rdata,

    input  logic       reg_check,   // testbench asks for a register compare
    output int         err_count,
    output int         check_count
);

    pat_idx_t offset_m;
    pat_idx_t base_m;
    int       len_m;
    int       beat_m;
    logic     in_read;
    logic     wr_pending;   // last w seen and b not yet taken
    logic     after_reset;
    logic     r_stalled;
    logic     b_stalled;
    logic     ar_fire_q;    // transfers on the previous sample
    logic     aw_fire_q;
    logic     wlast_fire_q;
    axi_r_t   r_prev;
    count_t   rd_bursts_m;
    count_t   rd_beats_m;
    count_t   wr_beats_m;
    float32_t expect_float;
    beat_t    expect_beat;
    count_t   expect_reg;

    // double exponent rebiased to single
    function automatic float32_t int_to_float(input int n);
        real         rv;
        logic [63:0] dbits;
        logic [10:0] e11;
        if (n == 0) begin
            return '0;
        end
        rv = $itor(n);
        dbits = $realtobits(rv);
        e11 = dbits[62:52] - 11'd896;
        return {dbits[63], e11[7:0], dbits[51:29]};
    endfunction

    task automatic report(input string msg);
        $display("ERR %0t: %s", $time, msg);
        err_count++;
    endtask

    task automatic compare(input logic ok, input string msg);
        check_count++;
        if (!ok) begin
            report(msg);
        end
    endtask

    // sampled mid-cycle where inputs and outputs are settled
    always @(negedge ap_clk) begin
        if (rst) begin
            offset_m     = '0;
            in_read      = 1'b0;
            wr_pending   = 1'b0;
            after_reset  = 1'b1;
            r_stalled    = 1'b0;
            b_stalled    = 1'b0;
            ar_fire_q    = 1'b0;
            aw_fire_q    = 1'b0;
            wlast_fire_q = 1'b0;
            rd_bursts_m  = '0;
            rd_beats_m   = '0;
            wr_beats_m   = '0;
        end else begin
            if (after_reset) begin
                compare(!(arready || awready || wready || rvalid || bvalid || r.last),
                        "handshake outputs not low after reset");
                after_reset = 1'b0;
            end
            if (arready) begin
                compare(arvalid, "arready raised without arvalid");
            end
            if (awready) begin
                compare(awvalid, "awready raised without awvalid");
            end
            if (ar_fire_q) begin
                compare(rvalid, "rvalid late after the ar transfer");
            end
            if (aw_fire_q) begin
                compare(wready, "wready late after the aw transfer");
            end
            if (wlast_fire_q) begin
                compare(bvalid, "bvalid late after the last w transfer");
            end
            if (r_stalled) begin
                compare(rvalid && r == r_prev, "r beat changed while rready was low");
            end
            if (rvalid) begin
                compare(in_read, "r beat outside a read burst");
                if (in_read && rready) begin
                    expect_float = int_to_float((int'(base_m) + beat_m) % 32);
                    expect_beat  = {floats_per_beat{expect_float}};
                    compare(r.data == expect_beat,
                            $sformatf("beat %0d carries %h, expected %h",
                                      beat_m, r.data[31:0], expect_float));
                    compare(r.last == (beat_m == len_m),
                            $sformatf("rlast %0b on beat %0d of len %0d", r.last, beat_m, len_m));
                    rd_beats_m++;
                    if (beat_m == len_m) begin
                        in_read = 1'b0;
                        rd_bursts_m++;
                    end
                    beat_m++;
                end
            end
            r_stalled = rvalid && !rready;
            r_prev    = r;
            if (arvalid && arready) begin
                in_read = 1'b1;
                base_m  = offset_m; // offset frozen for the burst
                len_m   = int'(ar.len);
                beat_m  = 0;
            end
            if (b_stalled) begin
                compare(bvalid, "bvalid dropped before bready");
            end
            if (bvalid) begin
                compare(wr_pending, "bvalid without a completed write burst");
                if (bready) begin
                    wr_pending = 1'b0;
                end
            end
            b_stalled = bvalid && !bready;
            if (wvalid && wready) begin
                wr_beats_m++;
                if (w.last) begin
                    wr_pending = 1'b1;
                end
            end
            ar_fire_q    = arvalid && arready;
            aw_fire_q    = awvalid && awready;
            wlast_fire_q = wvalid && wready && w.last;
            if (cfg_we && cfg_addr == reg_pattern_offset) begin
                offset_m = cfg_wdata[pat_idx_w-1:0];
            end
            if (reg_check) begin
                case (cfg_addr)
                    reg_pattern_offset: expect_reg = count_t'(offset_m);
                    reg_rd_bursts:      expect_reg = rd_bursts_m;
                    reg_rd_beats:       expect_reg = rd_beats_m;
                    default:            expect_reg = wr_beats_m;
                endcase
                compare(cfg_rdata == expect_reg,
                        $sformatf("register %0d reads %0d, expected %0d",
                                  cfg_addr, cfg_rdata, expect_reg));
            end
        end
    end

endmodule

// File: hw/hbm_emu_top.sv
`timescale 1ns/1ps

module hbm_emu_top import hbm_emu_pkg::*; (
    input  logic       ap_clk,
    input  logic       rst,

    input  axi_ar_t    ar,
    input  logic       arvalid,
    output logic       arready,
    input  axi_aw_t    aw,
    input  logic       awvalid,
    output logic       awready,
    input  axi_w_t     w,
    input  logic       wvalid,
    output logic       wready,
    output axi_r_t     r,
    output logic       rvalid,
    input  logic       rready,
    output logic       bvalid,
    input  logic       bready,

    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  count_t     cfg_wdata,
    output count_t     cfg_rdata
);

    emu_event_t events;
    pat_idx_t   pattern_offset;
    pat_idx_t   pat_idx;
    float32_t   pattern_value;

    hbm_channel_emu u_emu (
        .ap_clk         (ap_clk),
        .rst            (rst),
        .ar             (ar),
        .arvalid        (arvalid),
        .arready        (arready),
        .aw             (aw),
        .awvalid        (awvalid),
        .awready        (awready),
        .w              (w),
        .wvalid         (wvalid),
        .wready         (wready),
        .r              (r),
        .rvalid         (rvalid),
        .rready         (rready),
        .bvalid         (bvalid),
        .bready         (bready),
        .pattern_offset (pattern_offset),
        .pat_idx        (pat_idx),
        .pattern_value  (pattern_value),
        .events         (events)
    );

    float_pattern_gen u_gen (
        .pat_idx (pat_idx),
        .value   (pattern_value)
    );

    emu_config_regs u_regs (
        .ap_clk         (ap_clk),
        .rst            (rst),
        .cfg_we         (cfg_we),
        .cfg_addr       (cfg_addr),
        .cfg_wdata      (cfg_wdata),
        .cfg_rdata      (cfg_rdata),
        .events         (events),
        .pattern_offset (pattern_offset)
    );

endmodule

// File: hw/emu_config_regs.sv
`timescale 1ns/1ps

module emu_config_regs import hbm_emu_pkg::*; (
    input  logic       ap_clk,
    input  logic       rst,

    input  logic       cfg_we,
    input  logic [1:0] cfg_addr,
    input  count_t     cfg_wdata,
    output count_t     cfg_rdata,

    input  emu_event_t events,
    output pat_idx_t   pattern_offset
);

    pat_idx_t offset_q;
    count_t   rd_bursts;
    count_t   rd_beats;
    count_t   wr_beats;

    assign pattern_offset = offset_q;

    // only the offset is writable
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            offset_q <= '0;
        end else if (cfg_we && cfg_addr == reg_pattern_offset) begin
            offset_q <= cfg_wdata[pat_idx_w-1:0];
        end
    end

    // status counters, wrap on overflow
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            rd_bursts <= '0;
            rd_beats  <= '0;
            wr_beats  <= '0;
        end else begin
            if (events.rd_burst_done) begin
                rd_bursts <= rd_bursts + 32'd1;
            end
            if (events.rd_beat) begin
                rd_beats <= rd_beats + 32'd1;
            end
            if (events.wr_beat) begin
                wr_beats <= wr_beats + 32'd1;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            reg_pattern_offset: cfg_rdata = count_t'(offset_q); // zero-extended
            reg_rd_bursts:      cfg_rdata = rd_bursts;
            reg_rd_beats:       cfg_rdata = rd_beats;
            reg_wr_beats:       cfg_rdata = wr_beats;
            default:            cfg_rdata = '0;
        endcase
    end

endmodule

// File: hw/hbm_channel_emu.sv
`timescale 1ns/1ps

module hbm_channel_emu import hbm_emu_pkg::*; (
    input  logic       ap_clk,
    input  logic       rst,

    input  axi_ar_t    ar,
    input  logic       arvalid,
    output logic       arready,

    input  axi_aw_t    aw,       // address and length unused
    input  logic       awvalid,
    output logic       awready,

    input  axi_w_t     w,
    input  logic       wvalid,
    output logic       wready,

    output axi_r_t     r,
    output logic       rvalid,
    input  logic       rready,

    output logic       bvalid,
    input  logic       bready,

    input  pat_idx_t   pattern_offset,
    output pat_idx_t   pat_idx,
    input  float32_t   pattern_value,

    output emu_event_t events
);

    emu_state_t state;
    emu_state_t next_state;

    burst_len_t len_q;    // arlen of current burst
    burst_len_t beat_cnt;
    pat_idx_t   base_q;   // offset sampled at ar accept

    logic ar_fire;
    logic aw_fire;
    logic r_fire;
    logic w_fire;
    logic b_fire;

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign r_fire  = rvalid && rready;
    assign w_fire  = wvalid && wready;
    assign b_fire  = bvalid && bready;

    // handshake outputs decoded from state only
    always_comb begin
        arready = (state == addr_r);
        awready = (state == addr_w);
        wready  = (state == write);
        rvalid  = (state == read);
        bvalid  = (state == resp_w);
    end

    assign pat_idx = base_q + pat_idx_t'(beat_cnt); // wraps mod 32

    always_comb begin
        r.data = {floats_per_beat{pattern_value}};
        r.last = (state == read) && (beat_cnt == len_q);
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (arvalid) begin
                    next_state = addr_r; // reads take priority
                end else if (awvalid) begin
                    next_state = addr_w;
                end
            end
            addr_r: begin
                next_state = ar_fire ? read : idle;
            end
            read: begin
                if (r_fire && r.last) begin
                    next_state = idle;
                end
            end
            addr_w: begin
                next_state = aw_fire ? write : idle;
            end
            write: begin
                if (w_fire && w.last) begin
                    next_state = resp_w; // wlast trusted, awlen ignored
                end
            end
            resp_w: begin
                if (b_fire) begin
                    next_state = idle;
                end
            end
            default: begin
                next_state = idle;
            end
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (rst) begin
            state    <= idle;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            if (ar_fire) begin
                beat_cnt <= '0;
            end else if (r_fire) begin
                beat_cnt <= beat_cnt + 8'd1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (ar_fire) begin
            len_q  <= ar.len;
            base_q <= pattern_offset;
        end
    end

    // one-cycle pulses, one edge after the transfer
    always_ff @(posedge ap_clk) begin
        if (rst) begin
            events <= '0;
        end else begin
            events.rd_beat       <= r_fire;
            events.rd_burst_done <= r_fire && r.last;
            events.wr_beat       <= w_fire;
        end
    end

endmodule

// File: hw/float_pattern_gen.sv
`timescale 1ns/1ps

module float_pattern_gen import hbm_emu_pkg::*; (
    input  pat_idx_t pat_idx,
    output float32_t value
);

    logic [2:0]             lead;     // position of leading one
    logic [float_exp_w-1:0] exponent;
    logic [float_man_w-1:0] mantissa;
    logic                   is_zero;

    // priority search, highest set bit wins
    always_comb begin
        lead = '0;
        for (int i = 0; i < pat_idx_w; i++) begin
            if (pat_idx[i]) begin
                lead = 3'(i);
            end
        end
    end

    assign is_zero = (pat_idx == '0);

    always_comb begin
        exponent = float_exp_w'(float_exp_bias + int'(lead));
        // leading one lands on bit 23 and falls off the top
        mantissa = float_man_w'(pat_idx) << (float_man_w - int'(lead));
    end

    always_comb begin
        if (is_zero) begin
            value = '0;
        end else begin
            value = {1'b0, exponent, mantissa}; // always positive
        end
    end

endmodule

// File: hw/hbm_emu_pkg.sv
package hbm_emu_pkg;

    localparam int phit_size       = 512;
    localparam int dwidth_aximm    = 64;
    localparam int floats_per_beat = phit_size / 32;
    localparam int pat_idx_w       = 5;

    // ieee single layout
    localparam int float_exp_w    = 8;
    localparam int float_man_w    = 23;
    localparam int float_exp_bias = 127;

    localparam logic [1:0] reg_pattern_offset = 2'd0;
    localparam logic [1:0] reg_rd_bursts      = 2'd1;
    localparam logic [1:0] reg_rd_beats       = 2'd2;
    localparam logic [1:0] reg_wr_beats       = 2'd3;

    typedef logic [dwidth_aximm-1:0]  addr_t;
    typedef logic [phit_size-1:0]     beat_t;
    typedef logic [phit_size/8-1:0]   strb_t;
    typedef logic [7:0]               burst_len_t; // beats minus one
    typedef logic [pat_idx_w-1:0]     pat_idx_t;
    typedef logic [31:0]              float32_t;
    typedef logic [31:0]              count_t;

    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_ar_t;

    typedef struct packed {
        addr_t      addr;
        burst_len_t len;
    } axi_aw_t;

    typedef struct packed {
        beat_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } axi_r_t;

    typedef struct packed {
        logic rd_beat;
        logic rd_burst_done;
        logic wr_beat;
    } emu_event_t;

    typedef enum logic [2:0] {
        idle,
        addr_r,
        read,
        addr_w,
        write,
        resp_w
    } emu_state_t;

endpackage
